// ==== hdl/gcu_pkg.sv ====
// gp9001 tile controller definitions
package gcu_pkg;

    // bus and tile ram widths
    localparam int DATA_W       = 16;
    localparam int PTR_W        = 13;
    localparam int LAYER_ADDR_W = 11;
    localparam int LAYER_NUM_W  = PTR_W - LAYER_ADDR_W;
    localparam int POS_W        = 13;
    localparam int MAX_LAYERS   = 3;

    // register select
    localparam int                   REG_NUM_W    = 8;
    localparam logic [REG_NUM_W-1:0] REG_SEL_MASK = 8'h8F;
    localparam logic [REG_NUM_W-1:0] REG_SEL_NONE = 8'hFF;
    localparam int                   REG_FLIP_BIT = 7;

    // scroll registers sit at base + 2*layer + axis, bg x first and text y last
    localparam logic [3:0] REG_SCROLL_BASE = 4'h0;

    // tile ram pointer, flat for arithmetic or split for layer routing
    typedef union packed {
        logic [PTR_W-1:0] flat;
        struct packed {
            logic [LAYER_NUM_W-1:0]  layer;
            logic [LAYER_ADDR_W-1:0] offset;
        } fields;
    } vram_ptr_u;

    // x offsets per layer, bg / fg / text
    localparam logic signed [POS_W-1:0] X_OFFS_NORMAL [MAX_LAYERS] = '{
        -13'sh1D6, -13'sh1D8, -13'sh1DA
    };
    localparam logic signed [POS_W-1:0] X_OFFS_FLIPPED [MAX_LAYERS] = '{
        -13'sh229, -13'sh227, -13'sh225
    };

    // y offsets are the same on every layer
    localparam logic signed [POS_W-1:0] Y_OFFS_NORMAL [MAX_LAYERS] = '{
        -13'sh1EF, -13'sh1EF, -13'sh1EF
    };
    localparam logic signed [POS_W-1:0] Y_OFFS_FLIPPED [MAX_LAYERS] = '{
        -13'sh210, -13'sh210, -13'sh210
    };

endpackage

// ==== hdl/scroll_layer.sv ====
// scroll layer registers and tile ram
`timescale 1ns/1ps

module scroll_layer
    import gcu_pkg::*;
(
    input  logic                    CLK96,
    input  logic                    RESET96,
    input  logic [DATA_W-1:0]       wr_data,
    input  logic [LAYER_ADDR_W-1:0] cpu_addr,
    input  logic                    ram_we,
    input  logic                    scroll_x_we,
    input  logic                    scroll_y_we,
    input  logic                    flip_value,
    output logic [DATA_W-1:0]       cpu_rdata,
    input  logic [LAYER_ADDR_W-1:0] render_addr,
    output logic [DATA_W-1:0]       render_data,
    output logic [DATA_W-1:0]       scroll_x,
    output logic [DATA_W-1:0]       scroll_y,
    output logic                    flip_x,
    output logic                    flip_y
);

    // 2048 words of tile data for this layer
    logic [DATA_W-1:0] tile_ram [2**LAYER_ADDR_W];

    // one write port, cpu and renderer read ports both registered
    always_ff @(posedge CLK96) begin
        if (ram_we) begin
            tile_ram[cpu_addr] <= wr_data;
        end
        cpu_rdata   <= tile_ram[cpu_addr];
        render_data <= tile_ram[render_addr];
    end

    // x axis scroll and flip
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            scroll_x <= '0;
            flip_x   <= 1'b0;
        end else if (scroll_x_we) begin
            scroll_x <= wr_data;
            flip_x   <= flip_value;
        end
    end

    // y axis scroll and flip
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            scroll_y <= '0;
            flip_y   <= 1'b0;
        end else if (scroll_y_we) begin
            scroll_y <= wr_data;
            flip_y   <= flip_value;
        end
    end

endmodule

// ==== hdl/scroll_position.sv ====
// effective scroll positions
`timescale 1ns/1ps

module scroll_position
    import gcu_pkg::*;
#(
    parameter int NUM_LAYERS = MAX_LAYERS
) (
    input  logic                                    CLK96,
    input  logic                                    RESET96,
    input  logic [NUM_LAYERS-1:0][DATA_W-1:0]       scroll_x,
    input  logic [NUM_LAYERS-1:0][DATA_W-1:0]       scroll_y,
    input  logic [NUM_LAYERS-1:0]                   flip_x,
    input  logic [NUM_LAYERS-1:0]                   flip_y,
    output logic signed [NUM_LAYERS-1:0][POS_W-1:0] pos_x,
    output logic signed [NUM_LAYERS-1:0][POS_W-1:0] pos_y
);

    // sums wrap at 13 bits, the upper scroll bits are dropped
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            for (int i = 0; i < NUM_LAYERS; i++) begin
                pos_x[i] <= X_OFFS_NORMAL[i];
                pos_y[i] <= Y_OFFS_NORMAL[i];
            end
        end else begin
            for (int i = 0; i < NUM_LAYERS; i++) begin
                pos_x[i] <= scroll_x[i][POS_W-1:0] +
                            (flip_x[i] ? X_OFFS_FLIPPED[i] : X_OFFS_NORMAL[i]);
                pos_y[i] <= scroll_y[i][POS_W-1:0] +
                            (flip_y[i] ? Y_OFFS_FLIPPED[i] : Y_OFFS_NORMAL[i]);
            end
        end
    end

endmodule

// ==== hdl/cpu_bus_ctrl.sv ====
// cpu bus controller
`timescale 1ns/1ps

module cpu_bus_ctrl
    import gcu_pkg::*;
#(
    parameter int NUM_LAYERS = MAX_LAYERS
) (
    input  logic                              CLK96,
    input  logic                              RESET96,
    input  logic                              op_select_reg,
    input  logic                              op_write_reg,
    input  logic                              op_set_ptr,
    input  logic                              op_write_ram,
    input  logic                              op_read_ram_h,
    input  logic                              op_read_ram_l,
    input  logic [DATA_W-1:0]                 din,
    output logic                              ack,
    output logic [DATA_W-1:0]                 dout,
    output logic [DATA_W-1:0]                 wr_data,
    output logic [LAYER_ADDR_W-1:0]           cpu_addr,
    output logic [NUM_LAYERS-1:0]             ram_we,
    output logic [NUM_LAYERS-1:0]             scroll_x_we,
    output logic [NUM_LAYERS-1:0]             scroll_y_we,
    output logic [NUM_LAYERS-1:0]             flip_value,
    input  logic [NUM_LAYERS-1:0][DATA_W-1:0] layer_rdata
);

    // progress through the current op
    localparam logic [1:0] STEP_IDLE = 2'd0;
    localparam logic [1:0] STEP_ONE  = 2'd1;
    localparam logic [1:0] STEP_TWO  = 2'd2;
    localparam logic [1:0] STEP_DONE = 2'd3;

    logic [1:0]             step;
    logic [REG_NUM_W-1:0]   reg_sel;
    vram_ptr_u              ptr;
    vram_ptr_u              acc_ptr;
    logic [LAYER_NUM_W-1:0] acc_layer;
    logic [3:0]             reg_idx;
    logic [DATA_W-1:0]      rd_sel;
    logic                   any_op;
    logic                   is_read;

    assign any_op  = op_select_reg | op_write_reg | op_set_ptr |
                     op_write_ram | op_read_ram_h | op_read_ram_l;
    assign is_read = op_read_ram_h | op_read_ram_l;

    // the cpu holds din until ack, so both write kinds take it straight
    assign wr_data = din;

    // every layer sees the same flip bit, only the strobed one keeps it
    assign flip_value = {NUM_LAYERS{reg_sel[REG_FLIP_BIT]}};

    // scroll register index, bit 0 is the axis
    assign reg_idx = reg_sel[3:0] - REG_SCROLL_BASE;

    // read-low looks at the word after the pointer
    always_comb begin
        acc_ptr.flat = ptr.flat + PTR_W'(op_read_ram_l);
    end

    // layer decode, numbers past NUM_LAYERS match nothing
    always_comb begin
        ram_we      = '0;
        scroll_x_we = '0;
        scroll_y_we = '0;
        rd_sel      = '0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (acc_layer == i) begin
                ram_we[i] = op_write_ram && (step == STEP_ONE);
                rd_sel    = layer_rdata[i];
            end
            if (reg_idx[3:1] == i) begin
                scroll_x_we[i] = op_write_reg && (step == STEP_IDLE) && !reg_idx[0];
                scroll_y_we[i] = op_write_reg && (step == STEP_IDLE) && reg_idx[0];
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            step      <= STEP_IDLE;
            ack       <= 1'b1;
            dout      <= '0;
            reg_sel   <= REG_SEL_NONE;
            ptr.flat  <= '0;
            cpu_addr  <= '0;
            acc_layer <= '0;
        end else if (!any_op) begin
            // strobes dropped, ready for the next op
            step <= STEP_IDLE;
            ack  <= 1'b1;
        end else begin
            case (step)
                STEP_IDLE: begin
                    ack       <= 1'b0;
                    step      <= STEP_ONE;
                    cpu_addr  <= acc_ptr.fields.offset;
                    acc_layer <= acc_ptr.fields.layer;
                    if (op_select_reg) begin
                        reg_sel <= din[REG_NUM_W-1:0] & REG_SEL_MASK;
                    end
                    if (op_set_ptr) begin
                        ptr.flat <= din[PTR_W-1:0];
                    end
                end
                STEP_ONE: begin
                    // ram write lands here, read data is being registered
                    if (op_write_ram || is_read) begin
                        step <= STEP_TWO;
                    end else begin
                        ack  <= 1'b1;
                        step <= STEP_DONE;
                    end
                end
                STEP_TWO: begin
                    if (op_write_ram) begin
                        ptr.flat <= ptr.flat + 1'b1;
                    end
                    if (is_read) begin
                        dout <= rd_sel;
                    end
                    ack  <= 1'b1;
                    step <= STEP_DONE;
                end
                default: begin
                    // strobe still held, nothing more to do
                    ack <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== hdl/gcu_top.sv ====
// gp9001 tile controller top
`timescale 1ns/1ps

module gcu_top
    import gcu_pkg::*;
#(
    parameter int NUM_LAYERS = MAX_LAYERS
) (
    input  logic                                   CLK96,
    input  logic                                   RESET96,
    input  logic                                   op_select_reg,
    input  logic                                   op_write_reg,
    input  logic                                   op_set_ptr,
    input  logic                                   op_write_ram,
    input  logic                                   op_read_ram_h,
    input  logic                                   op_read_ram_l,
    input  logic [DATA_W-1:0]                      din,
    output logic                                   ack,
    output logic [DATA_W-1:0]                      dout,
    input  logic [NUM_LAYERS-1:0][LAYER_ADDR_W-1:0] render_addr,
    output logic [NUM_LAYERS-1:0][DATA_W-1:0]      render_data,
    output logic signed [NUM_LAYERS-1:0][POS_W-1:0] pos_x,
    output logic signed [NUM_LAYERS-1:0][POS_W-1:0] pos_y
);

    // broadcast from the bus controller
    logic [DATA_W-1:0]       wr_data;
    logic [LAYER_ADDR_W-1:0] cpu_addr;

    // one bit per layer
    logic [NUM_LAYERS-1:0] ram_we;
    logic [NUM_LAYERS-1:0] scroll_x_we;
    logic [NUM_LAYERS-1:0] scroll_y_we;
    logic [NUM_LAYERS-1:0] flip_value;
    logic [NUM_LAYERS-1:0] flip_x;
    logic [NUM_LAYERS-1:0] flip_y;

    logic [NUM_LAYERS-1:0][DATA_W-1:0] layer_rdata;
    logic [NUM_LAYERS-1:0][DATA_W-1:0] scroll_x;
    logic [NUM_LAYERS-1:0][DATA_W-1:0] scroll_y;

    cpu_bus_ctrl #(
        .NUM_LAYERS (NUM_LAYERS)
    ) u_bus_ctrl (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .op_select_reg (op_select_reg),
        .op_write_reg  (op_write_reg),
        .op_set_ptr    (op_set_ptr),
        .op_write_ram  (op_write_ram),
        .op_read_ram_h (op_read_ram_h),
        .op_read_ram_l (op_read_ram_l),
        .din           (din),
        .ack           (ack),
        .dout          (dout),
        .wr_data       (wr_data),
        .cpu_addr      (cpu_addr),
        .ram_we        (ram_we),
        .scroll_x_we   (scroll_x_we),
        .scroll_y_we   (scroll_y_we),
        .flip_value    (flip_value),
        .layer_rdata   (layer_rdata)
    );

    // bg, fg and text layers in that order
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        scroll_layer u_layer (
            .CLK96       (CLK96),
            .RESET96     (RESET96),
            .wr_data     (wr_data),
            .cpu_addr    (cpu_addr),
            .ram_we      (ram_we[i]),
            .scroll_x_we (scroll_x_we[i]),
            .scroll_y_we (scroll_y_we[i]),
            .flip_value  (flip_value[i]),
            .cpu_rdata   (layer_rdata[i]),
            .render_addr (render_addr[i]),
            .render_data (render_data[i]),
            .scroll_x    (scroll_x[i]),
            .scroll_y    (scroll_y[i]),
            .flip_x      (flip_x[i]),
            .flip_y      (flip_y[i])
        );
    end

    scroll_position #(
        .NUM_LAYERS (NUM_LAYERS)
    ) u_scroll_pos (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .scroll_x (scroll_x),
        .scroll_y (scroll_y),
        .flip_x   (flip_x),
        .flip_y   (flip_y),
        .pos_x    (pos_x),
        .pos_y    (pos_y)
    );

endmodule

// ==== verification/tb_gcu_tasks.svh ====
// gcu cpu op and compare tasks

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

task automatic compare_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    end
endtask

task automatic compare_pos(input string name, input logic signed [POS_W-1:0] got,
                           input logic signed [POS_W-1:0] exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    end
endtask

// hand a check to the checker, then move on one cycle
task automatic request_check(input int kind);
    check_kind = kind;
    -> check_ev;
    @(negedge CLK96);
endtask

// called right after a falling edge, returns after another
task automatic run_op(input int op, input logic [DATA_W-1:0] data, input int hold);
    int waited;
    din         = data;
    strobes     = '0;
    strobes[op] = 1'b1;
    waited      = 0;
    do begin
        @(negedge CLK96);
        waited++;
    end while (ack !== 1'b0 && waited < ACK_TIMEOUT);
    if (ack !== 1'b0) begin
        stop_with_failure("timed out waiting for ack to fall after the op strobe");
    end
    waited = 0;
    do begin
        @(negedge CLK96);
        waited++;
    end while (ack !== 1'b1 && waited < ACK_TIMEOUT);
    if (ack !== 1'b1) begin
        stop_with_failure("timed out waiting for ack to rise again");
    end
    // strobe kept high past ack
    repeat (hold) request_check(CHK_ACK);
    strobes = '0;
    @(negedge CLK96);
endtask

task automatic select_reg(input logic [7:0] num);
    run_op(OP_SELECT, DATA_W'(num), 0);
    model_sel = num & 8'h8F;
endtask

task automatic write_reg(input logic [DATA_W-1:0] value);
    int idx;
    idx = model_sel[3:0];
    run_op(OP_WRITE_REG, value, 0);
    if (idx / 2 < NUM_LAYERS) begin
        model_scroll[idx / 2][idx % 2] = value;
        model_flip[idx / 2][idx % 2]   = model_sel[7];
    end
endtask

task automatic set_ptr(input logic [PTR_W-1:0] addr);
    run_op(OP_SET_PTR, DATA_W'(addr), 0);
    model_ptr = addr;
endtask

task automatic write_word(input logic [DATA_W-1:0] value, input int hold);
    logic [LAYER_NUM_W-1:0] layer;
    layer = model_ptr[PTR_W-1:LAYER_ADDR_W];
    run_op(OP_WRITE_RAM, value, hold);
    if (int'(layer) < NUM_LAYERS) begin
        model_ram[layer][model_ptr[LAYER_ADDR_W-1:0]] = value;
    end
    model_ptr = model_ptr + 1'b1;
endtask

task automatic read_check(input int op);
    read_ptr = model_ptr + PTR_W'(op == OP_READ_L);
    run_op(op, '0, 0);
    request_check(CHK_DOUT);
endtask

task automatic render_check(input logic [LAYER_ADDR_W-1:0] offset);
    render_addr = {NUM_LAYERS{offset}};
    @(negedge CLK96);
    request_check(CHK_RENDER);
endtask

// ==== verification/tb_gcu.sv ====
// gcu testbench top
`timescale 1ns/1ps

module tb_gcu
    import gcu_pkg::*;
();

    localparam int NUM_LAYERS  = 3;
    localparam int ACK_TIMEOUT = 16;
    localparam int BURST_LEN   = 8;
    localparam int BURST_OFFS  = 16;

    // strobe positions in the strobes vector
    localparam int OP_SELECT    = 0;
    localparam int OP_WRITE_REG = 1;
    localparam int OP_SET_PTR   = 2;
    localparam int OP_WRITE_RAM = 3;
    localparam int OP_READ_H    = 4;
    localparam int OP_READ_L    = 5;

    // checker request kinds
    localparam int CHK_ACK    = 0;
    localparam int CHK_RESET  = 1;
    localparam int CHK_POS    = 2;
    localparam int CHK_DOUT   = 3;
    localparam int CHK_RENDER = 4;

    // amounts subtracted from the scroll value for each layer
    localparam logic [POS_W-1:0] X_SUB_NORMAL [3]  = '{13'h1D6, 13'h1D8, 13'h1DA};
    localparam logic [POS_W-1:0] X_SUB_FLIPPED [3] = '{13'h229, 13'h227, 13'h225};
    localparam logic [POS_W-1:0] Y_SUB_NORMAL      = 13'h1EF;
    localparam logic [POS_W-1:0] Y_SUB_FLIPPED     = 13'h210;

    logic                                    CLK96;
    logic                                    RESET96;
    logic [5:0]                              strobes;
    logic [DATA_W-1:0]                       din;
    logic                                    ack;
    logic [DATA_W-1:0]                       dout;
    logic [NUM_LAYERS-1:0][LAYER_ADDR_W-1:0] render_addr;
    logic [NUM_LAYERS-1:0][DATA_W-1:0]       render_data;
    logic signed [NUM_LAYERS-1:0][POS_W-1:0] pos_x;
    logic signed [NUM_LAYERS-1:0][POS_W-1:0] pos_y;

    // reference model state
    logic [PTR_W-1:0]  model_ptr;
    logic [7:0]        model_sel;
    logic [DATA_W-1:0] model_ram [NUM_LAYERS][2**LAYER_ADDR_W];
    logic [DATA_W-1:0] model_scroll [NUM_LAYERS][2];
    logic              model_flip [NUM_LAYERS][2];
    logic [PTR_W-1:0]  read_ptr;
    logic [31:0]       rng_state;
    int                check_kind;
    event              check_ev;

    gcu_top #(
        .NUM_LAYERS (NUM_LAYERS)
    ) dut (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .op_select_reg (strobes[OP_SELECT]),
        .op_write_reg  (strobes[OP_WRITE_REG]),
        .op_set_ptr    (strobes[OP_SET_PTR]),
        .op_write_ram  (strobes[OP_WRITE_RAM]),
        .op_read_ram_h (strobes[OP_READ_H]),
        .op_read_ram_l (strobes[OP_READ_L]),
        .din           (din),
        .ack           (ack),
        .dout          (dout),
        .render_addr   (render_addr),
        .render_data   (render_data),
        .pos_x         (pos_x),
        .pos_y         (pos_y)
    );

    always #10 CLK96 = ~CLK96;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // scroll value plus the offset for the current flip state wraps at 13 bits
    function automatic logic signed [POS_W-1:0] expected_pos(input int layer, input int axis);
        logic [POS_W-1:0] sub;
        if (axis == 0) begin
            sub = model_flip[layer][0] ? X_SUB_FLIPPED[layer] : X_SUB_NORMAL[layer];
        end else begin
            sub = model_flip[layer][1] ? Y_SUB_FLIPPED : Y_SUB_NORMAL;
        end
        return model_scroll[layer][axis][POS_W-1:0] - sub;
    endfunction

    // layer numbers past the last layer read as zero
    function automatic logic [DATA_W-1:0] expected_read(input logic [PTR_W-1:0] addr);
        if (int'(addr[PTR_W-1:LAYER_ADDR_W]) >= NUM_LAYERS) begin
            return '0;
        end
        return model_ram[addr[PTR_W-1:LAYER_ADDR_W]][addr[LAYER_ADDR_W-1:0]];
    endfunction

    `include "tb_gcu_tasks.svh"

    // checker runs at a falling edge when the stimulus asks
    always @(check_ev) begin
        if (check_kind == CHK_ACK || check_kind == CHK_RESET) begin
            compare_bit("ack", ack, 1'b1);
        end
        if (check_kind == CHK_RESET) begin
            compare_word("dout", dout, '0);
        end
        if (check_kind == CHK_DOUT) begin
            compare_word("dout", dout, expected_read(read_ptr));
        end
        for (int l = 0; l < NUM_LAYERS; l++) begin
            if (check_kind == CHK_RESET || check_kind == CHK_POS) begin
                compare_pos($sformatf("pos_x[%0d]", l), pos_x[l], expected_pos(l, 0));
                compare_pos($sformatf("pos_y[%0d]", l), pos_y[l], expected_pos(l, 1));
            end
            if (check_kind == CHK_RENDER) begin
                compare_word($sformatf("render_data[%0d]", l), render_data[l],
                             expected_read({LAYER_NUM_W'(l), render_addr[l]}));
            end
        end
    end

    initial begin
        CLK96       = 1'b0;
        RESET96     = 1'b1;
        strobes     = '0;
        din         = '0;
        render_addr = '0;
        rng_state   = 32'hb80c_7d63;
        check_kind  = CHK_ACK;
        model_ptr   = '0;
        model_sel   = 8'hFF;
        read_ptr    = '0;
        for (int l = 0; l < NUM_LAYERS; l++) begin
            for (int a = 0; a < 2; a++) begin
                model_scroll[l][a] = '0;
                model_flip[l][a]   = 1'b0;
            end
        end
        repeat (8) @(posedge CLK96);
        @(negedge CLK96);
        RESET96 = 1'b0;
        @(negedge CLK96);
        request_check(CHK_RESET);

        // all six scroll registers with the flip bit set and then clear
        for (int f = 0; f < 2; f++) begin
            for (int r = 0; r < 6; r++) begin
                select_reg({(f == 0) ? 4'hF : 4'h7, 4'(r)});
                write_reg(DATA_W'(next_random()));
                request_check(CHK_POS);
            end
        end
        select_reg(8'h06);
        write_reg(DATA_W'(next_random()));
        request_check(CHK_POS);
        select_reg(8'h0E);
        write_reg(DATA_W'(next_random()));
        request_check(CHK_POS);

        // one burst per layer at the same offset
        for (int l = 0; l < NUM_LAYERS; l++) begin
            set_ptr(PTR_W'(l * 2048 + BURST_OFFS));
            for (int i = 0; i < BURST_LEN; i++) begin
                write_word(DATA_W'(next_random()), 0);
            end
        end
        for (int l = 0; l < NUM_LAYERS; l++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                set_ptr(PTR_W'(l * 2048 + BURST_OFFS + i));
                read_check(OP_READ_H);
                if (i < BURST_LEN - 1) begin
                    read_check(OP_READ_L);
                end
            end
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            render_check(LAYER_ADDR_W'(BURST_OFFS + i));
        end

        // old sprite area
        set_ptr(13'h1800 + BURST_OFFS);
        for (int i = 0; i < BURST_LEN; i++) begin
            write_word(DATA_W'(next_random()), 0);
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            render_check(LAYER_ADDR_W'(BURST_OFFS + i));
        end
        set_ptr(13'h1810);
        read_check(OP_READ_H);
        read_check(OP_READ_L);
        set_ptr(13'h1FFF);
        read_check(OP_READ_H);

        // long hold on a ram write must step the pointer once
        set_ptr(13'h0840);
        write_word(DATA_W'(next_random()), 5);
        write_word(DATA_W'(next_random()), 0);
        set_ptr(13'h0840);
        read_check(OP_READ_H);
        read_check(OP_READ_L);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verification
hdl/gcu_pkg.sv
hdl/scroll_layer.sv
hdl/scroll_position.sv
hdl/cpu_bus_ctrl.sv
hdl/gcu_top.sv
verification/tb_gcu.sv

// ==== Bender.yml ====
package:
  name: gcu

sources:
  - hdl/gcu_pkg.sv
  - hdl/scroll_layer.sv
  - hdl/scroll_position.sv
  - hdl/cpu_bus_ctrl.sv
  - hdl/gcu_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_gcu.sv
